// File: hw/mem_map_pkg.sv
package mem_map_pkg;

  // Host region select codes
  typedef enum logic [1:0] {
    SEL_CONTROLLER = 2'b00,
    SEL_MOD        = 2'b01,
    SEL_DUTY_TABLE = 2'b10,
    SEL_UNUSED     = 2'b11
  } region_sel_e;

  // Sub-select inside the controller region, taken from addr[13:8]
  localparam logic [5:0] CNT_SEL_MAIN   = 6'h00;
  localparam logic [5:0] CNT_SEL_FILTER = 6'h01;

  // Configuration registers shadowed in the main controller RAM
  localparam logic [7:0] ADDR_MOD_WR_SEGMENT = 8'h20;
  localparam logic [7:0] ADDR_DUTY_WR_PAGE   = 8'h21;

  // Configuration view of a host data word
  typedef struct packed {
    logic [14:0] reserved;
    logic        cfg_bit;
  } host_cfg_t;

  // One host word, seen as memory data or as a config value
  typedef union packed {
    logic [15:0] raw;
    host_cfg_t   cfg;
  } host_word_u;

  // Single-strobe host request
  typedef struct packed {
    logic        en;
    logic        we;
    region_sel_e sel;
    logic [13:0] addr;
    host_word_u  data;
  } host_req_t;

endpackage

// File: hw/core_bus_pkg.sv
package core_bus_pkg;

  // Controller RAM port, read and write
  typedef struct packed {
    logic        we;
    logic [7:0]  addr;
    logic [15:0] din;
  } ctl_req_t;

  // Filter coefficients, read only
  typedef struct packed {
    logic [6:0] addr;
  } filter_req_t;

  // Duty table lookup, idx[8] is the page
  typedef struct packed {
    logic [8:0] idx;
  } duty_req_t;

  // Modulation table lookup
  // Segment field sized for two segments
  typedef struct packed {
    logic       segment;
    logic [7:0] idx;
  } mod_req_t;

endpackage

// File: hw/dual_port_ram.sv
`timescale 1ns/1ns

module dual_port_ram #(
  parameter int DEPTH   = 256,
  parameter bit B_WRITE = 1'b0,
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic              bus_clk,
  input  logic              a_en,
  input  logic              a_we,
  input  logic [ADDR_W-1:0] a_addr,
  input  logic [15:0]       a_din,
  output logic [15:0]       a_dout,
  input  logic              b_we,
  input  logic [ADDR_W-1:0] b_addr,
  input  logic [15:0]       b_din,
  output logic [15:0]       b_dout,
  input  logic              arst_n
);

  logic [15:0] mem [DEPTH];

  // Storage, host port first then core port
  always_ff @(posedge bus_clk) begin
    if (a_en && a_we) begin
      mem[a_addr] <= a_din;
    end
    if (B_WRITE && b_we) begin
      mem[b_addr] <= b_din;
    end
  end

  // Host read data only changes on a host read
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      a_dout <= '0;
    end else if (a_en && !a_we) begin
      a_dout <= mem[a_addr];
    end
  end

  // Core port reads every cycle, old data on a same-cycle write
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      b_dout <= '0;
    end else begin
      b_dout <= mem[b_addr];
    end
  end

  a_addr_in_range: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
    a_en |-> (a_addr < DEPTH)
  ) else $error("host address out of range");

endmodule

// File: hw/bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder #(
  parameter int NUM_SEGMENT = 2,
  localparam int SEG_W = (NUM_SEGMENT > 1) ? $clog2(NUM_SEGMENT) : 1
) (
  input  logic                  bus_clk,
  input  logic                  arst_n,
  input  mem_map_pkg::host_req_t host_req,
  output logic                  ctl_en,
  output logic                  filter_en,
  output logic                  duty_en,
  output logic                  mod_en,
  output logic [SEG_W-1:0]      wr_segment,
  output logic                  wr_page
);

  logic [5:0] cnt_sel;
  logic       is_ctl_region;

  assign cnt_sel       = host_req.addr[13:8];
  assign is_ctl_region = host_req.en && (host_req.sel == mem_map_pkg::SEL_CONTROLLER);

  // At most one region enable per request
  assign ctl_en    = is_ctl_region && (cnt_sel == mem_map_pkg::CNT_SEL_MAIN);
  assign filter_en = is_ctl_region && (cnt_sel == mem_map_pkg::CNT_SEL_FILTER);
  assign duty_en   = host_req.en && (host_req.sel == mem_map_pkg::SEL_DUTY_TABLE);
  assign mod_en    = host_req.en && (host_req.sel == mem_map_pkg::SEL_MOD);

  // Config registers follow controller writes to their addresses.
  // The same write also lands in the controller RAM.
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_segment <= '0;
      wr_page    <= 1'b0;
    end else if (ctl_en && host_req.we) begin
      case (host_req.addr[7:0])
        mem_map_pkg::ADDR_MOD_WR_SEGMENT: begin
          wr_segment <= SEG_W'(host_req.data.cfg.cfg_bit);
        end
        mem_map_pkg::ADDR_DUTY_WR_PAGE: begin
          wr_page <= host_req.data.cfg.cfg_bit;
        end
        default: begin
        end
      endcase
    end
  end

  // Only one memory may see a host access
  region_enables_exclusive: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
    $onehot0({ctl_en, filter_en, duty_en, mod_en})
  ) else $error("more than one region enable active");

endmodule

// File: hw/segment_bank.sv
`timescale 1ns/1ns

module segment_bank #(
  parameter int NUM_SEGMENT = 2,
  parameter int MOD_DEPTH   = 256,
  localparam int SEG_W  = (NUM_SEGMENT > 1) ? $clog2(NUM_SEGMENT) : 1,
  localparam int ADDR_W = (MOD_DEPTH > 1) ? $clog2(MOD_DEPTH) : 1
) (
  input  logic                  bus_clk,
  input  logic                  arst_n,
  input  logic                  wr_en,
  input  logic                  wr_we,
  input  logic [SEG_W-1:0]      wr_segment,
  input  logic [7:0]            wr_addr,
  input  logic [15:0]           wr_data,
  input  core_bus_pkg::mod_req_t mod_req,
  output logic [15:0]           mod_rdata
);

  logic [15:0]      seg_dout [NUM_SEGMENT];
  logic [SEG_W-1:0] rd_seg_q;

  for (genvar i = 0; i < NUM_SEGMENT; i++) begin : gen_seg
    logic seg_en;

    // Host writes only reach the selected segment
    assign seg_en = wr_en && (wr_segment == SEG_W'(i));

    dual_port_ram #(
      .DEPTH  (MOD_DEPTH),
      .B_WRITE(1'b0)
    ) i_mod_ram (
      .bus_clk(bus_clk),
      .a_en   (seg_en),
      .a_we   (wr_we),
      .a_addr (wr_addr[ADDR_W-1:0]),
      .a_din  (wr_data),
      .a_dout (),
      .b_we   (1'b0),
      .b_addr (mod_req.idx[ADDR_W-1:0]),
      .b_din  (16'h0000),
      .b_dout (seg_dout[i]),
      .arst_n (arst_n)
    );
  end

  // Segment of the read in flight, same latency as the RAMs
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_seg_q <= '0;
    end else begin
      rd_seg_q <= SEG_W'(mod_req.segment);
    end
  end

  assign mod_rdata = seg_dout[rd_seg_q];

  rd_segment_in_range: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
    (mod_req.segment < NUM_SEGMENT)
  ) else $error("modulation read segment out of range");

endmodule

// File: hw/memory_map_top.sv
`timescale 1ns/1ns

module memory_map_top #(
  parameter int NUM_SEGMENT = 2,
  parameter int MOD_DEPTH   = 256,
  localparam int SEG_W = (NUM_SEGMENT > 1) ? $clog2(NUM_SEGMENT) : 1
) (
  input  logic                      bus_clk,
  input  logic                      arst_n,
  input  mem_map_pkg::host_req_t    host_req,
  output logic [15:0]               host_rdata,
  input  core_bus_pkg::ctl_req_t    ctl_req,
  output logic [15:0]               ctl_rdata,
  input  core_bus_pkg::filter_req_t filter_req,
  output logic [15:0]               filter_rdata,
  input  core_bus_pkg::duty_req_t   duty_req,
  output logic [15:0]               duty_rdata,
  input  core_bus_pkg::mod_req_t    mod_req,
  output logic [15:0]               mod_rdata
);

  logic             ctl_en;
  logic             filter_en;
  logic             duty_en;
  logic             mod_en;
  logic [SEG_W-1:0] wr_segment;
  logic             wr_page;

  bus_decoder #(
    .NUM_SEGMENT(NUM_SEGMENT)
  ) i_bus_decoder (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .host_req  (host_req),
    .ctl_en    (ctl_en),
    .filter_en (filter_en),
    .duty_en   (duty_en),
    .mod_en    (mod_en),
    .wr_segment(wr_segment),
    .wr_page   (wr_page)
  );

  // Controller registers, shared with the core
  dual_port_ram #(
    .DEPTH  (256),
    .B_WRITE(1'b1)
  ) i_ctl_ram (
    .bus_clk(bus_clk),
    .a_en   (ctl_en),
    .a_we   (host_req.we),
    .a_addr (host_req.addr[7:0]),
    .a_din  (host_req.data.raw),
    .a_dout (host_rdata),
    .b_we   (ctl_req.we),
    .b_addr (ctl_req.addr),
    .b_din  (ctl_req.din),
    .b_dout (ctl_rdata),
    .arst_n (arst_n)
  );

  dual_port_ram #(
    .DEPTH  (128),
    .B_WRITE(1'b0)
  ) i_filter_ram (
    .bus_clk(bus_clk),
    .a_en   (filter_en),
    .a_we   (host_req.we),
    .a_addr (host_req.addr[6:0]),
    .a_din  (host_req.data.raw),
    .a_dout (),
    .b_we   (1'b0),
    .b_addr (filter_req.addr),
    .b_din  (16'h0000),
    .b_dout (filter_rdata),
    .arst_n (arst_n)
  );

  // Two pages of 256 entries, host page from the config register
  dual_port_ram #(
    .DEPTH  (512),
    .B_WRITE(1'b0)
  ) i_duty_ram (
    .bus_clk(bus_clk),
    .a_en   (duty_en),
    .a_we   (host_req.we),
    .a_addr ({wr_page, host_req.addr[7:0]}),
    .a_din  (host_req.data.raw),
    .a_dout (),
    .b_we   (1'b0),
    .b_addr (duty_req.idx),
    .b_din  (16'h0000),
    .b_dout (duty_rdata),
    .arst_n (arst_n)
  );

  segment_bank #(
    .NUM_SEGMENT(NUM_SEGMENT),
    .MOD_DEPTH  (MOD_DEPTH)
  ) i_segment_bank (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .wr_en     (mod_en),
    .wr_we     (host_req.we),
    .wr_segment(wr_segment),
    .wr_addr   (host_req.addr[7:0]),
    .wr_data   (host_req.data.raw),
    .mod_req   (mod_req),
    .mod_rdata (mod_rdata)
  );

endmodule

// File: dv/memmap_tb.sv
`timescale 1ns/1ns

module memmap_tb;

  localparam int N_RAND  = 100;
  localparam int N_MIX   = 150;
  localparam int N_TAB   = 150;
  localparam int N_SEGW  = 24;
  localparam int N_PIPE  = 96;
  localparam int N_BAD   = 40;
  localparam int N_SWEEP = 64;
  // Phases plus the reset checks and short fixed sequences
  localparam int N_OPS = 2 * N_RAND + N_MIX + N_TAB + 2 * N_SEGW + N_PIPE + N_BAD + N_SWEEP + 24;
  localparam int TIMEOUT_CYCLES = 4 * N_OPS;

  logic bus_clk = 1'b0;
  logic arst_n;
  mem_map_pkg::host_req_t    host_req, h_n;
  core_bus_pkg::ctl_req_t    ctl_req, c_n;
  core_bus_pkg::filter_req_t filter_req, f_n;
  core_bus_pkg::duty_req_t   duty_req, d_n;
  core_bus_pkg::mod_req_t    mod_req, m_n;
  logic [15:0] host_rdata, ctl_rdata, filter_rdata, duty_rdata, mod_rdata;

  integer seed = 32'h5f74_b2e9;
  int     cycle_cnt = 0;
  int     err_cnt = 0;

  // Shadow memories, with a flag for every entry already written
  logic [15:0] ctl_m [256];
  logic [15:0] filt_m [128];
  logic [15:0] duty_m [512];
  logic [15:0] mod_m [2][256];
  bit          ctl_v [256];
  bit          filt_v [128];
  bit          duty_v [512];
  bit          mod_v [2][256];
  logic        seg_m;
  logic        page_m;

  // Results expected after the last edge
  logic [15:0] host_exp, ctl_exp, filt_exp, duty_exp, mod_exp;
  bit          host_pend, ctl_pend, filt_pend, duty_pend, mod_pend;

  memory_map_top #(
    .NUM_SEGMENT(2),
    .MOD_DEPTH  (256)
  ) i_dut (.*);

  always #5 bus_clk = ~bus_clk;

  always @(posedge bus_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

  task automatic stop_on_error();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_host(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: host_rdata is %h, expected %h", $time, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_core(input string port, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s read data is %h, expected %h", $time, port, got, exp);
      stop_on_error();
    end
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic mem_map_pkg::host_req_t host_op(input logic we,
      input mem_map_pkg::region_sel_e sel, input logic [13:0] addr, input logic [15:0] data);
    mem_map_pkg::host_req_t req;
    req.en       = 1'b1;
    req.we       = we;
    req.sel      = sel;
    req.addr     = addr;
    req.data.raw = data;
    return req;
  endfunction

  // Reads see the memories before this edge's writes
  task automatic model_edge();
    logic [7:0] a;
    a         = h_n.addr[7:0];
    ctl_pend  = ctl_v[c_n.addr];
    ctl_exp   = ctl_m[c_n.addr];
    filt_pend = filt_v[f_n.addr];
    filt_exp  = filt_m[f_n.addr];
    duty_pend = duty_v[d_n.idx];
    duty_exp  = duty_m[d_n.idx];
    mod_pend  = mod_v[m_n.segment][m_n.idx];
    mod_exp   = mod_m[m_n.segment][m_n.idx];
    if (h_n.en && h_n.sel == mem_map_pkg::SEL_CONTROLLER) begin
      if (h_n.addr[13:8] == mem_map_pkg::CNT_SEL_MAIN && h_n.we) begin
        ctl_m[a] = h_n.data.raw;
        ctl_v[a] = 1'b1;
        if (a == mem_map_pkg::ADDR_MOD_WR_SEGMENT) seg_m = h_n.data.raw[0];
        if (a == mem_map_pkg::ADDR_DUTY_WR_PAGE) page_m = h_n.data.raw[0];
      end else if (h_n.addr[13:8] == mem_map_pkg::CNT_SEL_MAIN) begin
        host_pend = ctl_v[a];
        host_exp  = ctl_m[a];
      end else if (h_n.addr[13:8] == mem_map_pkg::CNT_SEL_FILTER && h_n.we) begin
        filt_m[a[6:0]] = h_n.data.raw;
        filt_v[a[6:0]] = 1'b1;
      end
    end else if (h_n.en && h_n.we && h_n.sel == mem_map_pkg::SEL_DUTY_TABLE) begin
      duty_m[{page_m, a}] = h_n.data.raw;
      duty_v[{page_m, a}] = 1'b1;
    end else if (h_n.en && h_n.we && h_n.sel == mem_map_pkg::SEL_MOD) begin
      mod_m[seg_m][a] = h_n.data.raw;
      mod_v[seg_m][a] = 1'b1;
    end
    if (c_n.we) begin
      ctl_m[c_n.addr] = c_n.din;
      ctl_v[c_n.addr] = 1'b1;
    end
  endtask

  // One bus cycle: check the last edge, then drive the next requests
  task automatic step();
    @(negedge bus_clk);
    if (host_pend) check_host(host_rdata, host_exp);
    if (ctl_pend) check_core("ctl", ctl_rdata, ctl_exp);
    if (filt_pend) check_core("filter", filter_rdata, filt_exp);
    if (duty_pend) check_core("duty", duty_rdata, duty_exp);
    if (mod_pend) check_core("mod", mod_rdata, mod_exp);
    host_req   = h_n;
    ctl_req    = c_n;
    filter_req = f_n;
    duty_req   = d_n;
    mod_req    = m_n;
    model_edge();
    h_n.en = 1'b0;
    c_n.we = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] q;
    arst_n     = 1'b0;
    h_n        = '0;
    c_n        = '0;
    f_n        = '0;
    d_n        = '0;
    m_n        = '0;
    host_req   = '0;
    ctl_req    = '0;
    filter_req = '0;
    duty_req   = '0;
    mod_req    = '0;
    seg_m      = 1'b0;
    page_m     = 1'b0;
    repeat (4) @(posedge bus_clk);
    @(negedge bus_clk);
    check_host(host_rdata, 16'h0000);
    check_core("ctl", ctl_rdata, 16'h0000);
    check_core("filter", filter_rdata, 16'h0000);
    check_core("duty", duty_rdata, 16'h0000);
    check_core("mod", mod_rdata, 16'h0000);
    arst_n    = 1'b1;
    host_pend = 1'b1;
    host_exp  = 16'h0000;

    // Before any config write, segment 0 and page 0
    for (int i = 0; i < 4; i++) begin
      h_n = host_op(1'b1, mem_map_pkg::SEL_MOD, 14'(i), 16'(rand32()));
      step();
      h_n = host_op(1'b1, mem_map_pkg::SEL_DUTY_TABLE, 14'(i), 16'(rand32()));
      step();
    end
    for (int i = 0; i < 5; i++) begin
      m_n.segment = 1'b0;
      m_n.idx     = 8'(i);
      d_n.idx     = 9'(i);
      step();
    end

    // Main controller RAM, host writes then host and core reads
    for (int i = 0; i < N_RAND; i++) begin
      r   = rand32();
      h_n = host_op(1'b1, mem_map_pkg::SEL_CONTROLLER,
                    {mem_map_pkg::CNT_SEL_MAIN, 2'b00, r[5:0]}, r[31:16]);
      step();
    end
    h_n = host_op(1'b1, mem_map_pkg::SEL_CONTROLLER,
                  {mem_map_pkg::CNT_SEL_MAIN, mem_map_pkg::ADDR_MOD_WR_SEGMENT}, 16'ha5a5);
    step();
    h_n = host_op(1'b1, mem_map_pkg::SEL_CONTROLLER,
                  {mem_map_pkg::CNT_SEL_MAIN, mem_map_pkg::ADDR_DUTY_WR_PAGE}, 16'h5a5b);
    step();
    for (int i = 0; i < N_RAND + 2; i++) begin
      r   = rand32();
      h_n = host_op(1'b0, mem_map_pkg::SEL_CONTROLLER,
                    {mem_map_pkg::CNT_SEL_MAIN, 2'b00, r[5:0]}, 16'h0000);
      if (i >= N_RAND) h_n.addr[7:0] = mem_map_pkg::ADDR_MOD_WR_SEGMENT + 8'(i - N_RAND);
      c_n.addr = {2'b00, r[13:8]};
      step();
    end

    // Host and core traffic on the shared controller RAM
    for (int i = 0; i < N_MIX; i++) begin
      r   = rand32();
      q   = rand32();
      h_n = host_op(r[0], mem_map_pkg::SEL_CONTROLLER,
                    {mem_map_pkg::CNT_SEL_MAIN, 1'b0, r[7:1]}, r[31:16]);
      c_n.we   = q[0];
      c_n.addr = {1'b0, q[7:1]};
      c_n.din  = q[31:16];
      if (h_n.we && c_n.we && h_n.addr[7:0] == c_n.addr) c_n.we = 1'b0;
      step();
    end

    // Filter and duty tables, with the host page moving
    for (int i = 0; i < N_TAB; i++) begin
      r = rand32();
      q = rand32();
      case (r[1:0])
        2'd0: h_n = host_op(1'b1, mem_map_pkg::SEL_CONTROLLER,
                            {mem_map_pkg::CNT_SEL_FILTER, r[9:2]}, r[31:16]);
        2'd3: h_n = host_op(1'b1, mem_map_pkg::SEL_CONTROLLER,
                            {mem_map_pkg::CNT_SEL_MAIN, mem_map_pkg::ADDR_DUTY_WR_PAGE}, r[31:16]);
        default: h_n = host_op(1'b1, mem_map_pkg::SEL_DUTY_TABLE, {9'h000, r[6:2]}, r[31:16]);
      endcase
      f_n.addr = q[6:0];
      d_n.idx  = {q[8], 3'b000, q[13:9]};
      step();
    end

    // Fill both segments, then read them back to back
    for (int s = 0; s < 2; s++) begin
      r   = rand32();
      h_n = host_op(1'b1, mem_map_pkg::SEL_CONTROLLER,
                    {mem_map_pkg::CNT_SEL_MAIN, mem_map_pkg::ADDR_MOD_WR_SEGMENT}, {r[15:1], 1'(s)});
      step();
      for (int i = 0; i < N_SEGW; i++) begin
        h_n = host_op(1'b1, mem_map_pkg::SEL_MOD, 14'(i), 16'(rand32()));
        step();
      end
    end
    for (int i = 0; i < N_PIPE; i++) begin
      r           = rand32();
      m_n.segment = i[0];
      m_n.idx     = 8'(r[7:0] % N_SEGW);
      step();
    end

    // Unused select code and unknown sub-selects
    for (int i = 0; i < N_BAD; i++) begin
      r = rand32();
      if (r[0]) begin
        h_n = host_op(1'b1, mem_map_pkg::SEL_UNUSED, {r[13:8], 2'b00, r[5:0]}, r[31:16]);
      end else begin
        h_n = host_op(1'b1, mem_map_pkg::SEL_CONTROLLER,
                      {r[13:8] | 6'h02, 2'b00, r[5:0]}, r[31:16]);
      end
      step();
    end
    for (int i = 0; i < N_SWEEP; i++) begin
      r   = rand32();
      h_n = host_op(1'b0, mem_map_pkg::SEL_CONTROLLER,
                    {mem_map_pkg::CNT_SEL_MAIN, 8'(i)}, 16'h0000);
      c_n.addr    = 8'(64 + i);
      f_n.addr    = r[6:0];
      d_n.idx     = {r[8], 3'b000, r[13:9]};
      m_n.segment = r[14];
      m_n.idx     = 8'(r[23:16] % N_SEGW);
      step();
    end
    repeat (2) step();

    if (err_cnt == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stop_on_error();
    end
  end

endmodule

// File: memmap.f
hw/mem_map_pkg.sv
hw/core_bus_pkg.sv
hw/dual_port_ram.sv
hw/bus_decoder.sv
hw/segment_bank.sv
hw/memory_map_top.sv
dv/memmap_tb.sv
